/* all.f */
logic/cnn_pkg.sv
logic/feature_window.sv
logic/conv_pe.sv
logic/result_store.sv
logic/cnn_ctrl.sv
logic/cnn_top.sv
test/cnn_tb.sv

/* logic/cnn_ctrl.sv */
module cnn_ctrl (
	input logic clk,
	input logic reset,
	input cnn_pkg::apb_req_t apb_req,
	output cnn_pkg::apb_rsp_t apb_rsp,
	input cnn_pkg::inst_t instruct,
	input logic inst_empty,
	output logic inst_req,
	output cnn_pkg::pix_wr_t pix_wr,
	output cnn_pkg::coef_wr_t coef_wr,
	output cnn_pkg::pe_cfg_t pe_cfg,
	output logic [2:0] win_row,
	output logic [2:0] win_col,
	output cnn_pkg::res_tag_t tag,
	output logic [5:0] res_rd_index,
	input logic [cnn_pkg::RES_W-1:0] res_rd_data
);

	logic [7:0] word_idx;
	logic access, wr_ok;
	logic in_feat, in_coef, in_res, is_status;
	logic [31:0] prdata;
	logic slv_err;

	logic busy, draining;
	logic [1:0] drain_cnt;
	logic [2:0] row, col;
	logic cfg_pool;
	logic issuing;
	logic [5:0] full_index, pool_index;

	logic bias_pend;
	logic [1:0] bias_kernel;
	logic signed [15:0] bias_value;

	////////////////////////////////////////////////////////////////////////////
	// APB decode
	////////////////////////////////////////////////////////////////////////////
	assign word_idx = apb_req.paddr[cnn_pkg::APB_AW-1:2];
	assign access = apb_req.psel & apb_req.penable;
	assign wr_ok = access & apb_req.pwrite & ~busy;

	assign in_feat = word_idx < cnn_pkg::FEAT_BASE + 8'(cnn_pkg::MAP_DIM * cnn_pkg::MAP_DIM);
	assign in_coef = word_idx >= cnn_pkg::COEF_BASE
		&& word_idx < cnn_pkg::COEF_BASE + 8'(cnn_pkg::NUM_KERNELS * cnn_pkg::TAPS);
	assign in_res = word_idx >= cnn_pkg::RES_BASE
		&& word_idx < cnn_pkg::RES_BASE + 8'(cnn_pkg::OUT_DIM * cnn_pkg::OUT_DIM);
	assign is_status = word_idx == cnn_pkg::STATUS_IDX;

	assign pix_wr = '{en: wr_ok & in_feat, index: 6'(word_idx - cnn_pkg::FEAT_BASE),
		pixel: apb_req.pwdata[cnn_pkg::PIX_W-1:0]};

	// Pending bias wins the port over a host write
	always_comb begin
		if (bias_pend)
			coef_wr = '{en: 1'b1, is_bias: 1'b1, index: {4'b0, bias_kernel}, value: bias_value};
		else
			coef_wr = '{en: wr_ok & in_coef, is_bias: 1'b0,
				index: 6'(word_idx - cnn_pkg::COEF_BASE), value: apb_req.pwdata[15:0]};
	end

	assign res_rd_index = 6'(word_idx - cnn_pkg::RES_BASE);

	always_comb begin
		prdata = '0;
		if (in_res && !busy)
			prdata = {{(32 - cnn_pkg::RES_W){res_rd_data[cnn_pkg::RES_W-1]}}, res_rd_data};
		else if (is_status)
			prdata = {31'b0, busy};
	end

	assign slv_err = access & (apb_req.pwrite ? (~(in_feat | in_coef) | busy)
		: (in_res & busy));

	assign apb_rsp = '{prdata: prdata, pready: access, pslverr: slv_err};

	////////////////////////////////////////////////////////////////////////////
	// Instruction fetch and position sequencer
	////////////////////////////////////////////////////////////////////////////
	assign inst_req = ~busy & ~inst_empty; // FWFT head taken this cycle
	assign issuing = busy & ~draining;

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			draining <= 1'b0;
			drain_cnt <= '0;
			row <= '0;
			col <= '0;
			cfg_pool <= 1'b0;
			pe_cfg <= '0;
			bias_pend <= 1'b0;
		end else begin
			bias_pend <= inst_req && instruct.bias.opcode == cnn_pkg::OP_BIAS;
			if (inst_req && instruct.conv.opcode == cnn_pkg::OP_CONV) begin
				busy <= 1'b1;
				draining <= 1'b0;
				row <= '0;
				col <= '0;
				cfg_pool <= instruct.conv.pool;
				pe_cfg <= '{kernel: instruct.conv.kernel, shift: instruct.conv.shift,
					relu: instruct.conv.relu};
			end else if (issuing) begin
				if (col == 3'(cnn_pkg::OUT_DIM - 1)) begin
					col <= '0;
					if (row == 3'(cnn_pkg::OUT_DIM - 1)) begin
						draining <= 1'b1; // Last position issued
						drain_cnt <= '0;
					end else begin
						row <= row + 3'd1;
					end
				end else begin
					col <= col + 3'd1;
				end
			end else if (draining) begin
				// Busy covers three cycles after the last issue
				if (drain_cnt == 2'd2) begin
					busy <= 1'b0;
					draining <= 1'b0;
				end else begin
					drain_cnt <= drain_cnt + 2'd1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (inst_req) begin
			bias_kernel <= instruct.bias.kernel;
			bias_value <= instruct.bias.bias;
		end
	end

	assign full_index = 6'(row) * 6'(cnn_pkg::OUT_DIM) + 6'(col);
	assign pool_index = 6'(row >> 1) * 6'(cnn_pkg::POOL_DIM) + 6'(col >> 1);

	assign win_row = row;
	assign win_col = col;
	assign tag = '{valid: issuing, index: cfg_pool ? pool_index : full_index,
		merge: cfg_pool & (row[0] | col[0])};

	a_conv_sets_busy: assert property (@(posedge clk) disable iff (reset)
		inst_req && instruct.conv.opcode == cnn_pkg::OP_CONV |=> busy && !inst_req);
	a_penable_psel: assert property (@(posedge clk) disable iff (reset)
		apb_req.penable |-> apb_req.psel);

endmodule

/* logic/cnn_pkg.sv */
package cnn_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Sizes
	////////////////////////////////////////////////////////////////////////////
	localparam int MAP_DIM = 8;
	localparam int OUT_DIM = 6; // Valid conv area
	localparam int POOL_DIM = 3;
	localparam int TAPS = 9;
	localparam int NUM_KERNELS = 4;
	localparam int PIX_W = 8;
	localparam int ACC_W = 20;
	localparam int RES_W = 16;
	localparam int APB_AW = 10;

	// Word index map, taken from paddr[9:2]
	localparam logic [7:0] FEAT_BASE = 8'd0;
	localparam logic [7:0] COEF_BASE = 8'd64; // kernel*9 + tap
	localparam logic [7:0] RES_BASE = 8'd128;
	localparam logic [7:0] STATUS_IDX = 8'd255; // Bit 0 busy

	localparam logic [1:0] OP_BIAS = 2'd1;
	localparam logic [1:0] OP_CONV = 2'd2;

	////////////////////////////////////////////////////////////////////////////
	// Instruction word, two views of the same 32 bits
	////////////////////////////////////////////////////////////////////////////
	typedef struct packed {
		logic [1:0] opcode;
		logic [1:0] kernel;
		logic [3:0] shift; // Arithmetic right shift after bias
		logic relu;
		logic pool; // 2x2 max pool into 3x3
		logic [21:0] pad;
	} conv_inst_t;

	typedef struct packed {
		logic [1:0] opcode;
		logic [1:0] kernel;
		logic [11:0] pad;
		logic signed [15:0] bias;
	} bias_inst_t;

	typedef union packed {
		conv_inst_t conv;
		bias_inst_t bias;
	} inst_t;

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [APB_AW-1:0] paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic pready;
		logic pslverr;
	} apb_rsp_t;

	typedef struct packed {
		logic en;
		logic [5:0] index;
		logic signed [PIX_W-1:0] pixel;
	} pix_wr_t;

	// For a bias the index is the kernel number
	typedef struct packed {
		logic en;
		logic is_bias;
		logic [5:0] index;
		logic signed [15:0] value;
	} coef_wr_t;

	typedef struct packed {
		logic [TAPS-1:0][PIX_W-1:0] pix; // Row major, tap 0 top left
	} window_t;

	typedef struct packed {
		logic [1:0] kernel;
		logic [3:0] shift;
		logic relu;
	} pe_cfg_t;

	typedef struct packed {
		logic valid;
		logic [5:0] index;
		logic merge; // Max with stored value
	} res_tag_t;

	typedef struct packed {
		res_tag_t tag;
		logic signed [RES_W-1:0] value;
	} res_wr_t;

endpackage

/* logic/cnn_top.sv */
module cnn_top (
	input logic clk,
	input logic reset,
	input cnn_pkg::apb_req_t apb_req,
	output cnn_pkg::apb_rsp_t apb_rsp,
	input cnn_pkg::inst_t instruct,
	input logic inst_empty,
	output logic inst_req
);

	cnn_pkg::pix_wr_t pix_wr;
	cnn_pkg::coef_wr_t coef_wr;
	cnn_pkg::pe_cfg_t pe_cfg;
	cnn_pkg::window_t window;
	cnn_pkg::res_tag_t tag;
	cnn_pkg::res_wr_t res;
	logic [2:0] win_row, win_col;
	logic [5:0] res_rd_index;
	logic [cnn_pkg::RES_W-1:0] res_rd_data;

	cnn_ctrl i_ctrl (
		.clk(clk),
		.reset(reset),
		.apb_req(apb_req),
		.apb_rsp(apb_rsp),
		.instruct(instruct),
		.inst_empty(inst_empty),
		.inst_req(inst_req),
		.pix_wr(pix_wr),
		.coef_wr(coef_wr),
		.pe_cfg(pe_cfg),
		.win_row(win_row),
		.win_col(win_col),
		.tag(tag),
		.res_rd_index(res_rd_index),
		.res_rd_data(res_rd_data)
	);

	feature_window i_window (
		.clk(clk),
		.reset(reset),
		.pix_wr(pix_wr),
		.win_row(win_row),
		.win_col(win_col),
		.window(window)
	);

	conv_pe i_pe (
		.clk(clk),
		.reset(reset),
		.coef_wr(coef_wr),
		.pe_cfg(pe_cfg),
		.window(window),
		.tag(tag),
		.res(res)
	);

	result_store i_store (
		.clk(clk),
		.reset(reset),
		.res(res),
		.rd_index(res_rd_index),
		.rd_data(res_rd_data)
	);

endmodule

/* logic/conv_pe.sv */
module conv_pe (
	input logic clk,
	input logic reset,
	input cnn_pkg::coef_wr_t coef_wr,
	input cnn_pkg::pe_cfg_t pe_cfg,
	input cnn_pkg::window_t window,
	input cnn_pkg::res_tag_t tag,
	output cnn_pkg::res_wr_t res
);

	logic signed [cnn_pkg::PIX_W-1:0] weight [cnn_pkg::NUM_KERNELS * cnn_pkg::TAPS];
	logic signed [cnn_pkg::RES_W-1:0] bias_bank [cnn_pkg::NUM_KERNELS];
	logic [5:0] wbase;

	logic signed [2*cnn_pkg::PIX_W-1:0] prod [cnn_pkg::TAPS];
	logic signed [cnn_pkg::ACC_W-1:0] acc, shifted;
	logic signed [cnn_pkg::RES_W-1:0] sat_value, res_value_q;
	cnn_pkg::res_tag_t tag_win, tag_prod, res_tag_q;

	////////////////////////////////////////////////////////////////////////////
	// Kernel and bias bank
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (coef_wr.en) begin
			if (coef_wr.is_bias)
				bias_bank[coef_wr.index[1:0]] <= coef_wr.value;
			else
				weight[coef_wr.index] <= coef_wr.value[cnn_pkg::PIX_W-1:0]; // 8 bit weights
		end
	end

	assign wbase = 6'(pe_cfg.kernel) * 6'(cnn_pkg::TAPS);

	// Stage one, nine products
	always_ff @(posedge clk) begin
		for (int t = 0; t < cnn_pkg::TAPS; t++) begin
			prod[t] <= $signed(window.pix[t]) * weight[wbase + 6'(t)];
		end
	end

	// Stage two, sum with bias, shift, ReLU, saturate
	always_comb begin
		acc = cnn_pkg::ACC_W'(bias_bank[pe_cfg.kernel]);
		for (int t = 0; t < cnn_pkg::TAPS; t++) begin
			acc = acc + cnn_pkg::ACC_W'(prod[t]);
		end
		shifted = acc >>> pe_cfg.shift;
		if (pe_cfg.relu && shifted[cnn_pkg::ACC_W-1])
			sat_value = '0;
		else if (&shifted[cnn_pkg::ACC_W-1:cnn_pkg::RES_W-1]
			|| ~|shifted[cnn_pkg::ACC_W-1:cnn_pkg::RES_W-1])
			sat_value = shifted[cnn_pkg::RES_W-1:0]; // Fits in 16 bits
		else if (shifted[cnn_pkg::ACC_W-1])
			sat_value = {1'b1, {(cnn_pkg::RES_W - 1){1'b0}}};
		else
			sat_value = {1'b0, {(cnn_pkg::RES_W - 1){1'b1}}};
	end

	always_ff @(posedge clk) begin
		res_value_q <= sat_value;
	end

	// Tag arrives with the position, one cycle ahead of the window
	always_ff @(posedge clk) begin
		if (reset) begin
			tag_win <= '0;
			tag_prod <= '0;
			res_tag_q <= '0;
		end else begin
			tag_win <= tag;
			tag_prod <= tag_win;
			res_tag_q <= tag_prod;
		end
	end

	assign res = '{tag: res_tag_q, value: res_value_q};

endmodule

/* logic/feature_window.sv */
module feature_window (
	input logic clk,
	input logic reset,
	input cnn_pkg::pix_wr_t pix_wr,
	input logic [2:0] win_row,
	input logic [2:0] win_col,
	output cnn_pkg::window_t window
);

	logic [cnn_pkg::PIX_W-1:0] pix_mem [cnn_pkg::MAP_DIM * cnn_pkg::MAP_DIM];

	////////////////////////////////////////////////////////////////////////////
	// Feature map, row major, index = row*8 + col
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (pix_wr.en)
			pix_mem[pix_wr.index] <= pix_wr.pixel;
	end

	// 3x3 window with top left corner at (win_row, win_col)
	always_ff @(posedge clk) begin
		for (int t = 0; t < cnn_pkg::TAPS; t++) begin
			window.pix[t] <= pix_mem[{win_row + 3'(t / 3), win_col + 3'(t % 3)}];
		end
	end

	// Window must stay inside the 8x8 map
	a_pos_range: assert property (@(posedge clk) disable iff (reset)
		win_row <= 3'(cnn_pkg::OUT_DIM - 1) && win_col <= 3'(cnn_pkg::OUT_DIM - 1));

endmodule

/* logic/result_store.sv */
module result_store (
	input logic clk,
	input logic reset,
	input cnn_pkg::res_wr_t res,
	input logic [5:0] rd_index,
	output logic [cnn_pkg::RES_W-1:0] rd_data
);

	logic signed [cnn_pkg::RES_W-1:0] res_mem [cnn_pkg::OUT_DIM * cnn_pkg::OUT_DIM];

	////////////////////////////////////////////////////////////////////////////
	// Results, overwrite or max merge
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < cnn_pkg::OUT_DIM * cnn_pkg::OUT_DIM; i++) begin
				res_mem[i] <= '0;
			end
		end else if (res.tag.valid) begin
			// First write of a pooled cell never merges
			if (!res.tag.merge || res.value > res_mem[res.tag.index])
				res_mem[res.tag.index] <= res.value;
		end
	end

	assign rd_data = (rd_index < 6'(cnn_pkg::OUT_DIM * cnn_pkg::OUT_DIM))
		? res_mem[rd_index] : '0;

	a_wr_index: assert property (@(posedge clk) disable iff (reset)
		res.tag.valid |-> res.tag.index < 6'(cnn_pkg::OUT_DIM * cnn_pkg::OUT_DIM));

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module cnn_tb -o cnn_sim
./obj_dir/cnn_sim | tee sim.log

if grep -q "^Test completed successfully$" sim.log; then
	echo "PASS"
else
	echo "FAIL"
	exit 1
fi

/* test/cnn_tb.sv */
module cnn_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int NUM_ROWS = 7;
	localparam int WAIT_LIMIT = 100;

	typedef struct packed {
		logic [1:0] bkern; // Kernel whose bias is set
		logic signed [15:0] bias;
		logic [1:0] kernel;
		logic [3:0] shift;
		logic relu;
		logic pool;
	} row_t;

	logic clk;
	logic reset;
	cnn_pkg::apb_req_t apb_req;
	cnn_pkg::apb_rsp_t apb_rsp;
	cnn_pkg::inst_t instruct;
	logic inst_empty;
	logic inst_req;

	cnn_pkg::inst_t inst_q [$];
	row_t rows [NUM_ROWS];
	int pix_m [64];
	int wgt_m [36];
	int bias_m [4];
	int exp_res [36];
	int seed = 32'h32a7_ed86;
	int errors = 0;
	int checks = 0;
	bit timed_out = 0;
	logic pop_now;

	cnn_top i_dut (
		.clk(clk),
		.reset(reset),
		.apb_req(apb_req),
		.apb_rsp(apb_rsp),
		.instruct(instruct),
		.inst_empty(inst_empty),
		.inst_req(inst_req)
	);

	always #2 clk = ~clk;

	task automatic check_value(input string name, input logic signed [31:0] got,
		input logic signed [31:0] expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, expected);
		end
	endtask

	task automatic report_timeout(input string what);
		errors++;
		timed_out = 1'b1;
		$display("Timeout at %0t while waiting for %s", $time, what);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Instruction FIFO model, first word falls through
	////////////////////////////////////////////////////////////////////////////
	task automatic present_head();
		if (inst_q.size() > 0) begin
			instruct = inst_q[0];
			inst_empty = 1'b0;
		end else begin
			instruct = '0;
			inst_empty = 1'b1;
		end
	endtask

	task automatic push_inst(input cnn_pkg::inst_t word);
		inst_q.push_back(word);
		present_head();
	endtask

	always begin
		@(negedge clk);
		pop_now = inst_req; // Taken at the coming edge
		if (inst_req === 1'b1 && inst_empty === 1'b1) begin
			errors++;
			$display("Error at %0t: inst_req raised while the FIFO is empty", $time);
		end
		@(posedge clk);
		#1;
		if (pop_now === 1'b1 && inst_q.size() > 0)
			void'(inst_q.pop_front());
		present_head();
	end

	////////////////////////////////////////////////////////////////////////////
	// APB master
	////////////////////////////////////////////////////////////////////////////
	task automatic apb_transfer(input logic write, input logic [7:0] word,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		int cnt;
		cnt = 0;
		@(posedge clk);
		#1;
		apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: {word, 2'b00},
			pwdata: wdata};
		@(posedge clk);
		#1;
		apb_req.penable = 1'b1;
		@(negedge clk);
		while (apb_rsp.pready !== 1'b1 && cnt < WAIT_LIMIT) begin
			@(negedge clk);
			cnt++;
		end
		if (apb_rsp.pready !== 1'b1)
			report_timeout("pready");
		rdata = apb_rsp.prdata;
		err = apb_rsp.pslverr;
		@(posedge clk);
		#1;
		apb_req = '0;
	endtask

	task automatic write_word(input logic [7:0] word, input logic [31:0] data,
		input logic exp_err);
		logic [31:0] unused;
		logic err;
		apb_transfer(1'b1, word, data, unused, err);
		check_value($sformatf("pslverr on write to word %0d", word), 32'(err), 32'(exp_err));
	endtask

	task automatic read_word(input logic [7:0] word, output logic [31:0] data,
		input logic exp_err);
		logic err;
		apb_transfer(1'b0, word, 32'h0, data, err);
		check_value($sformatf("pslverr on read of word %0d", word), 32'(err), 32'(exp_err));
	endtask

	// Fresh pixels and all four kernels
	task automatic load_operands();
		logic signed [7:0] v;
		for (int i = 0; i < 64; i++) begin
			v = 8'($random(seed));
			pix_m[i] = int'(v);
			write_word(cnn_pkg::FEAT_BASE + 8'(i), {24'b0, v}, 1'b0);
		end
		for (int i = 0; i < 36; i++) begin
			v = 8'($random(seed));
			wgt_m[i] = int'(v);
			write_word(cnn_pkg::COEF_BASE + 8'(i), {24'b0, v}, 1'b0);
		end
	endtask

	task automatic wait_fifo_drained();
		int cnt;
		cnt = 0;
		@(negedge clk);
		while (inst_q.size() != 0 && cnt < WAIT_LIMIT) begin
			@(negedge clk);
			cnt++;
		end
		if (inst_q.size() != 0)
			report_timeout("the instruction FIFO to drain");
	endtask

	task automatic wait_idle();
		logic [31:0] data;
		int cnt;
		cnt = 0;
		read_word(cnn_pkg::STATUS_IDX, data, 1'b0);
		while (data[0] !== 1'b0 && cnt < WAIT_LIMIT && !timed_out) begin
			read_word(cnn_pkg::STATUS_IDX, data, 1'b0);
			cnt++;
		end
		if (data[0] !== 1'b0)
			report_timeout("busy to drop");
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////////////
	function automatic int conv_value(input int y, input int x, input int k, input int sh,
		input bit relu);
		int acc;
		acc = bias_m[k];
		for (int dy = 0; dy < 3; dy++) begin
			for (int dx = 0; dx < 3; dx++) begin
				acc += pix_m[(y + dy) * 8 + x + dx] * wgt_m[k * 9 + dy * 3 + dx];
			end
		end
		acc = acc >>> sh;
		if (relu && acc < 0)
			acc = 0;
		if (acc > 32767)
			acc = 32767;
		else if (acc < -32768)
			acc = -32768;
		return acc;
	endfunction

	task automatic build_expected(input row_t cfg);
		int v;
		int idx;
		for (int y = 0; y < 6; y++) begin
			for (int x = 0; x < 6; x++) begin
				v = conv_value(y, x, int'(cfg.kernel), int'(cfg.shift), cfg.relu);
				if (cfg.pool) begin
					idx = (y / 2) * 3 + x / 2;
					if ((y % 2 == 0 && x % 2 == 0) || v > exp_res[idx])
						exp_res[idx] = v; // Max of the 2x2 cell
				end else begin
					exp_res[y * 6 + x] = v;
				end
			end
		end
	endtask

	task automatic run_row(input int n);
		row_t cfg;
		cnn_pkg::inst_t word;
		logic [31:0] data;
		int busy_idx;
		int count;
		cfg = rows[n];
		load_operands();
		bias_m[cfg.bkern] = int'(cfg.bias);
		word = '0;
		word.bias.opcode = cnn_pkg::OP_BIAS;
		word.bias.kernel = cfg.bkern;
		word.bias.bias = cfg.bias;
		push_inst(word);
		word = '0;
		word.conv.opcode = cnn_pkg::OP_CONV;
		word.conv.kernel = cfg.kernel;
		word.conv.shift = cfg.shift;
		word.conv.relu = cfg.relu;
		word.conv.pool = cfg.pool;
		push_inst(word);
		wait_fifo_drained();
		if (timed_out)
			return;
		// Conv running, host accesses are refused
		busy_idx = $random(seed) & 63;
		write_word(cnn_pkg::FEAT_BASE + 8'(busy_idx), {24'b0, ~8'(pix_m[busy_idx])}, 1'b1);
		read_word(cnn_pkg::RES_BASE, data, 1'b1);
		wait_idle();
		if (timed_out)
			return;
		write_word(8'd110, 32'h0000_5a5a, 1'b1); // Gap after the coefficients
		read_word(cnn_pkg::STATUS_IDX, data, 1'b0);
		check_value("busy", 32'(data[0]), 32'd0);
		build_expected(cfg);
		count = cfg.pool ? 9 : 36;
		for (int i = 0; i < count; i++) begin
			read_word(cnn_pkg::RES_BASE + 8'(i), data, 1'b0);
			check_value($sformatf("result[%0d] row %0d", i, n), $signed(data), exp_res[i]);
		end
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		apb_req = '0;
		instruct = '0;
		inst_empty = 1'b1;
		// bkern, bias, kernel, shift, relu, pool
		rows[0] = '{2'd0, 16'sd30000, 2'd0, 4'd0, 1'b0, 1'b0};
		rows[1] = '{2'd1, -16'sd30000, 2'd1, 4'd0, 1'b0, 1'b0};
		rows[2] = '{2'd2, 16'sd100, 2'd2, 4'd4, 1'b1, 1'b1};
		rows[3] = '{2'd3, -16'sd500, 2'd3, 4'd2, 1'b1, 1'b0};
		rows[4] = '{2'd1, 16'sd1234, 2'd0, 4'd3, 1'b0, 1'b1};
		rows[5] = '{2'd0, -16'sd2000, 2'd1, 4'd1, 1'b0, 1'b0};
		rows[6] = '{2'd3, 16'sd0, 2'd3, 4'd5, 1'b0, 1'b1};
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;
		for (int n = 0; n < NUM_ROWS; n++) begin
			if (!timed_out)
				run_row(n);
		end
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule
